// File: project.f
verilog/core_pkg.sv
verilog/bridge_settings_regs.sv
verilog/bridge_read_decode.sv
verilog/controller_router.sv
verilog/core_glue_top.sv
verif/core_glue_assert.sv
verif/tb_core_glue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the core glue testbench with Verilator, run it, grep for the pass line

cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --assert --timing --top-module tb_core_glue -f project.f \
  && ./obj_dir/Vtb_core_glue +verilator+error+limit+1000) \
  || { echo "$out"; echo "build or simulation ended with an error"; exit 1; }

echo "$out"
echo "$out" | grep -qx "Test completed successfully" && exit 0 || exit 1

// File: verif/core_glue_assert.sv
/*
 * core glue checker
 * concurrent assertions bound into the glue top level that check
 * register writes, the read mux, pad routing, reset values and
 * the reset hold length
 */

`timescale 1ns/1ps
`default_nettype none

module core_glue_assert
  import core_pkg::*;
(
  input wire            clk_74a,
  input wire            rst_n,
  input wire            bridge_wr,
  input wire            core_hold,
  input bridge_word_t   bridge_addr,
  input bridge_word_t   bridge_wr_data,
  input bridge_word_t   bridge_rd_data,
  input region_rd_t     region_rd,
  input pad_set_t       cont_keys,
  input pad_set_t       snac_keys,
  input pad_set_t       player_keys,
  input core_settings_t settings,
  input snac_cfg_t      snac_cfg
);

  // failed checks polled by the testbench
  int fail_cnt = 0;
  logic [HOLD_CNT_W-1:0] hold_len;
  logic [13:0]           last_analog;

  ////////////////////
  // reference rules
  ////////////////////

  // settings and analogizer word one clock later
  function automatic logic [25:0] next_regs(core_settings_t s, snac_cfg_t c, logic wr,
                                            bridge_word_t a, bridge_word_t d);
    if (wr) begin
      case (a)
        32'h0000_0100: s.turbo_tap_enable = d[0];
        32'h0000_0104: s.button6_enable = d[0];
        32'h0000_0108: s.button1_turbo_speed = d[1:0];
        32'h0000_010C: s.button2_turbo_speed = d[1:0];
        32'h0000_0200: s.overscan_enable = d[0];
        32'h0000_0204: s.extra_sprites_enable = d[0];
        32'h0000_0300: s.master_audio_boost = d[1:0];
        32'h0000_0304: s.adpcm_audio_boost = d[0];
        32'h0000_0308: s.cd_audio_boost = d[0];
        // only the low 14 bits are kept
        32'hF700_0000: c = snac_cfg_t'(d[13:0]);
        default: ;
      endcase
    end
    return {s, c};
  endfunction

  // first matching rule wins
  function automatic bridge_word_t read_model(bridge_word_t a, region_rd_t r,
                                              logic [13:0] raw);
    if (a == 32'hF700_0000) return {18'd0, raw};
    if (a[31:28] == 4'h2) return r.save_rd;
    if (a[31:28] == 4'h8) return r.mpu_ram_rd;
    if (a[31:24] == 8'hF0) return r.mpu_reg_rd;
    if (a[31:24] == 8'hF8) return r.cmd_rd;
    return '0;
  endfunction

  // tuples are players 1 to 4
  function automatic pad_set_t route_model(snac_cfg_t c, pad_set_t p, pad_set_t s);
    if (c.game_cont_type == 5'd0) return p;
    case (c.assignment)
      ASSIGN_P1:       return {s.p1, p.p2, p.p3, p.p4};
      ASSIGN_P2:       return {p.p1, s.p1, p.p3, p.p4};
      ASSIGN_P1P2:     return {s.p1, s.p2, p.p3, p.p4};
      ASSIGN_SWAP:     return {s.p2, s.p1, p.p3, p.p4};
      ASSIGN_ALL:      return {s.p1, s.p2, s.p3, s.p4};
      ASSIGN_REVERSED: return {s.p4, s.p3, s.p2, s.p1};
      ASSIGN_P3P4:     return {p.p1, p.p2, s.p1, s.p2};
      default:         return p;
    endcase
  endfunction

  // last analogizer word written over the bridge
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      last_analog <= '0;
    end else if (bridge_wr && bridge_addr == 32'hF700_0000) begin
      last_analog <= bridge_wr_data[13:0];
    end
  end

  // high cycles of core_hold since the last reload
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      hold_len <= '0;
    end else if (bridge_wr && bridge_addr == 32'h0000_0050) begin
      hold_len <= '0;
    end else if (core_hold) begin
      hold_len <= hold_len + 1'b1;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  a_write: assert property (@(posedge clk_74a) disable iff (!rst_n)
    rst_n |=> {settings, snac_cfg} == next_regs($past(settings), $past(snac_cfg),
      $past(bridge_wr), $past(bridge_addr), $past(bridge_wr_data)))
    else begin
      fail_cnt++;
      $error("ERR %0t: settings or analogizer word wrong after a bridge cycle", $time);
    end

  a_read: assert property (@(posedge clk_74a) disable iff (!rst_n)
    bridge_rd_data == read_model(bridge_addr, region_rd, last_analog))
    else begin
      fail_cnt++;
      $error("ERR %0t: read data %h wrong for address %h", $time, bridge_rd_data, bridge_addr);
    end

  a_route: assert property (@(posedge clk_74a) disable iff (!rst_n)
    rst_n |=> player_keys == route_model($past(snac_cfg), $past(cont_keys), $past(snac_keys)))
    else begin
      fail_cnt++;
      $error("ERR %0t: player keys %h do not match the routing table", $time, player_keys);
    end

  // values left by reset on the first edge after release
  a_reset: assert property (@(posedge clk_74a)
    $rose(rst_n) |-> settings == '0 && snac_cfg == '0 && !core_hold && player_keys == '0)
    else begin
      fail_cnt++;
      $error("ERR %0t: outputs not at their reset values", $time);
    end

  a_hold_start: assert property (@(posedge clk_74a) disable iff (!rst_n)
    bridge_wr && bridge_addr == 32'h0000_0050 |=> core_hold)
    else begin
      fail_cnt++;
      $error("ERR %0t: core_hold did not rise after a reset hold write", $time);
    end

  a_hold_len: assert property (@(posedge clk_74a) disable iff (!rst_n)
    $fell(core_hold) |-> hold_len == 21'd1048576)
    else begin
      fail_cnt++;
      $error("ERR %0t: core_hold was high for %0d cycles", $time, hold_len);
    end

endmodule

bind core_glue_top core_glue_assert i_assert (.*);

`default_nettype wire

// File: verif/tb_core_glue.sv
/*
 * core glue testbench
 * drives bridge writes, read addresses and pad words into the
 * glue top level, the bound checker compares the results
 */

`timescale 1ns/1ps
`default_nettype none

module tb_core_glue
  import core_pkg::*;
();

  logic           clk_74a;
  logic           rst_n;
  bridge_word_t   bridge_addr;
  logic           bridge_wr;
  bridge_word_t   bridge_wr_data;
  bridge_word_t   bridge_rd_data;
  region_rd_t     region_rd;
  pad_set_t       cont_keys;
  pad_set_t       snac_keys;
  core_settings_t settings;
  snac_cfg_t      snac_cfg;
  logic           core_hold;
  pad_set_t       player_keys;

  logic [31:0] rng_state = 32'hecf7;
  int          timeouts = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          mark = 0;

  // nine setting registers, then one unused address
  bridge_word_t write_addrs [10] = '{32'h100, 32'h104, 32'h108, 32'h10C, 32'h200,
                                     32'h204, 32'h300, 32'h304, 32'h308, 32'h110};
  // read addresses, random bits fill the mask
  bridge_word_t read_base [9] = '{32'hF700_0000, 32'h2000_0000, 32'h8000_0000,
                                  32'hF000_0000, 32'hF800_0000, 32'hF700_0004,
                                  32'h0000_0000, 32'h4000_0000, 32'hF100_0000};
  bridge_word_t read_mask [9] = '{32'h0, 32'h0FFF_FFFF, 32'h0FFF_FFFF, 32'h00FF_FFFF,
                                  32'h00FF_FFFF, 32'h0, 32'h0FFF_FFFF, 32'h0FFF_FFFF,
                                  32'h00FF_FFFF};

  core_glue_top i_dut (.*);

  // 20 ns period
  always #10 clk_74a = ~clk_74a;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic rand_word(output logic [31:0] w);
    rng_state = xorshift(rng_state);
    w = rng_state;
  endtask

  // fresh pad words and source words
  task automatic shuffle_inputs();
    logic [31:0] w [8];
    for (int i = 0; i < 8; i++) begin
      rand_word(w[i]);
    end
    cont_keys <= {w[0], w[1]};
    snac_keys <= {w[2], w[3]};
    region_rd <= {w[4], w[5], w[6], w[7]};
  endtask

  // one-cycle write strobe
  task automatic bus_write(bridge_word_t addr, bridge_word_t data);
    @(posedge clk_74a);
    bridge_addr    <= addr;
    bridge_wr      <= 1'b1;
    bridge_wr_data <= data;
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
  endtask

  // let pending checks settle, then report the test
  task automatic finish_test(string name);
    repeat (2) @(negedge clk_74a);
    tests_run++;
    if (i_dut.i_assert.fail_cnt + timeouts != mark) begin
      tests_failed++;
      $display("test %0d %s: FAILED", tests_run, name);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    mark = i_dut.i_assert.fail_cnt + timeouts;
  endtask

  initial begin
    bridge_word_t w;
    bridge_word_t d;
    int n;
    clk_74a = 1'b0;
    rst_n = 1'b0;
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    shuffle_inputs();

    ////////////////////
    // reset and pass-through
    repeat (5) @(posedge clk_74a);
    rst_n <= 1'b1;
    repeat (3) begin
      @(posedge clk_74a);
      shuffle_inputs();
    end
    finish_test("reset values");

    // every setting twice, unused address last
    for (int r = 0; r < 2; r++) begin
      foreach (write_addrs[i]) begin
        rand_word(d);
        bus_write(write_addrs[i], d);
      end
    end
    finish_test("settings writes");

    ////////////////////
    // read mux
    rand_word(d);
    bus_write(REG_ANALOGIZER, d);
    foreach (read_base[i]) begin
      rand_word(w);
      @(posedge clk_74a);
      bridge_addr <= read_base[i] | (w & read_mask[i]);
      shuffle_inputs();
    end
    finish_test("read mux");

    // reset hold, rise then count the high cycles
    bus_write(REG_RESET_HOLD, 32'd1);
    n = 0;
    do begin
      @(negedge clk_74a);
      n++;
    end while (!core_hold && n < 10);
    if (!core_hold) begin
      timeouts++;
      $display("core_hold never rose after the reset hold write");
    end
    n = 0;
    while (core_hold && n < 2 * int'(RESET_HOLD_CYCLES)) begin
      n++;
      @(negedge clk_74a);
    end
    if (core_hold) begin
      timeouts++;
      $display("core_hold still high after %0d cycles", n);
    end
    finish_test($sformatf("reset hold, %0d cycles high", n));

    ////////////////////
    // routing, codes 0..6 then 11
    for (int code = 0; code < 8; code++) begin
      rand_word(w);
      d = {18'd0, w[3:0], (code == 7) ? 4'hB : 4'(code), 1'b0, w[8:4] | 5'd1};
      bus_write(REG_ANALOGIZER, d);
      repeat (2) begin
        @(posedge clk_74a);
        shuffle_inputs();
      end
    end
    // snac off, all-snac code ignored
    bus_write(REG_ANALOGIZER, {18'd0, 4'd0, 4'(ASSIGN_ALL), 1'b0, 5'd0});
    repeat (2) begin
      @(posedge clk_74a);
      shuffle_inputs();
    end
    finish_test("controller routing");

    $display("tests %0d, failed %0d, assertion errors %0d, timeouts %0d",
             tests_run, tests_failed, i_dut.i_assert.fail_cnt, timeouts);
    if (tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/bridge_read_decode.sv
/*
 * bridge read decode
 * sorts the bridge address into a read region by priority
 * and muxes the matching read data, zero latency
 */

`timescale 1ns/1ps
`default_nettype none

module bridge_read_decode
  import core_pkg::*;
(
  input  bridge_word_t        bridge_addr,
  input  region_rd_t          region_rd,
  input  wire [ANALOG_W-1:0]  analog_raw,
  output bridge_word_t        bridge_rd_data
);

  bridge_region_e region;

  // first match wins, exact analogizer address ahead of the F-range
  always_comb begin
    if (bridge_addr == REG_ANALOGIZER) begin
      region = REGION_ANALOGIZER;
    end else if (bridge_addr[31:28] == SAVE_NIBBLE) begin
      region = REGION_SAVE;
    end else if (bridge_addr[31:28] == MPU_RAM_NIBBLE) begin
      region = REGION_MPU_RAM;
    end else if (bridge_addr[31:24] == MPU_REG_BYTE) begin
      region = REGION_MPU_REG;
    end else if (bridge_addr[31:24] == CMD_BYTE) begin
      region = REGION_CMD;
    end else begin
      region = REGION_NONE;
    end
  end

  // data mux
  always_comb begin
    case (region)
      REGION_ANALOGIZER: bridge_rd_data = {{(32-ANALOG_W){1'b0}}, analog_raw};
      REGION_SAVE:       bridge_rd_data = region_rd.save_rd;
      REGION_MPU_RAM:    bridge_rd_data = region_rd.mpu_ram_rd;
      REGION_MPU_REG:    bridge_rd_data = region_rd.mpu_reg_rd;
      REGION_CMD:        bridge_rd_data = region_rd.cmd_rd;
      // unmapped reads return zero
      default:           bridge_rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/bridge_settings_regs.sv
/*
 * bridge settings registers
 * decodes bridge write strobes into the emulator settings,
 * keeps the analogizer config word and runs the reset hold counter
 */

`timescale 1ns/1ps
`default_nettype none

module bridge_settings_regs
  import core_pkg::*;
(
  input  wire                 clk_74a,
  input  wire                 rst_n,
  input  bridge_word_t        bridge_addr,
  input  wire                 bridge_wr,
  input  bridge_word_t        bridge_wr_data,
  output core_settings_t      settings,
  output snac_cfg_t           snac_cfg,
  output logic [ANALOG_W-1:0] analog_raw,
  output logic                core_hold
);

  logic [HOLD_CNT_W-1:0] hold_cnt;
  logic                  hold_wr;

  ////////////////////
  // settings decode
  ////////////////////

  // one field per address, unknown addresses ignored
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      settings   <= '0;
      analog_raw <= '0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        REG_TURBO_TAP:     settings.turbo_tap_enable     <= bridge_wr_data[0];
        REG_BUTTON6:       settings.button6_enable       <= bridge_wr_data[0];
        REG_B1_TURBO:      settings.button1_turbo_speed  <= bridge_wr_data[1:0];
        REG_B2_TURBO:      settings.button2_turbo_speed  <= bridge_wr_data[1:0];
        REG_OVERSCAN:      settings.overscan_enable      <= bridge_wr_data[0];
        REG_EXTRA_SPRITES: settings.extra_sprites_enable <= bridge_wr_data[0];
        REG_MASTER_BOOST:  settings.master_audio_boost   <= bridge_wr_data[1:0];
        REG_ADPCM_BOOST:   settings.adpcm_audio_boost    <= bridge_wr_data[0];
        REG_CD_BOOST:      settings.cd_audio_boost       <= bridge_wr_data[0];
        // analogizer word, low 14 bits only
        REG_ANALOGIZER:    analog_raw <= bridge_wr_data[ANALOG_W-1:0];
        default: ;
      endcase
    end
  end

  // raw word reinterpreted field by field
  assign snac_cfg = snac_cfg_t'(analog_raw);

  ////////////////////
  // reset hold
  ////////////////////

  assign hold_wr = bridge_wr && (bridge_addr == REG_RESET_HOLD);

  // reload on every write, else count down to zero
  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      hold_cnt <= '0;
    end else if (hold_wr) begin
      hold_cnt <= RESET_HOLD_CYCLES;
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // high while the count runs, N cycles from load
  assign core_hold = (hold_cnt != '0);

endmodule

`default_nettype wire

// File: verilog/controller_router.sv
/*
 * controller router
 * picks pocket or SNAC pads for each player slot from the
 * analogizer assignment code, one register stage
 */

`timescale 1ns/1ps
`default_nettype none

module controller_router
  import core_pkg::*;
(
  input  wire       clk_74a,
  input  wire       rst_n,
  input  snac_cfg_t snac_cfg,
  input  pad_set_t  cont_keys,
  input  pad_set_t  snac_keys,
  output pad_set_t  player_keys
);

  pad_set_t route_next;

  ////////////////////
  // mapping table
  ////////////////////

  always_comb begin
    // pocket pads unless the table says otherwise
    route_next = cont_keys;
    // game_cont_type 0 means snac off
    if (snac_cfg.game_cont_type != 5'd0) begin
      case (snac_cfg.assignment)
        ASSIGN_P1: begin
          route_next.p1 = snac_keys.p1;
        end
        ASSIGN_P2: begin
          route_next.p2 = snac_keys.p1;
        end
        ASSIGN_P1P2: begin
          route_next.p1 = snac_keys.p1;
          route_next.p2 = snac_keys.p2;
        end
        // snac 2 on player 1 and back
        ASSIGN_SWAP: begin
          route_next.p1 = snac_keys.p2;
          route_next.p2 = snac_keys.p1;
        end
        ASSIGN_ALL: begin
          route_next = snac_keys;
        end
        ASSIGN_REVERSED: begin
          route_next.p1 = snac_keys.p4;
          route_next.p2 = snac_keys.p3;
          route_next.p3 = snac_keys.p2;
          route_next.p4 = snac_keys.p1;
        end
        // multitap, snac pads on players 3 and 4
        ASSIGN_P3P4: begin
          route_next.p3 = snac_keys.p1;
          route_next.p4 = snac_keys.p2;
        end
        // codes 7..15 keep the pocket pads
        default: ;
      endcase
    end
  end

  ////////////////////
  // output stage
  ////////////////////

  always_ff @(posedge clk_74a or negedge rst_n) begin
    if (!rst_n) begin
      player_keys <= '0;
    end else begin
      player_keys <= route_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/core_glue_top.sv
/*
 * core glue top
 * bridge-side glue of the handheld core: settings registers,
 * read data mux and controller routing, all on clk_74a
 */

`timescale 1ns/1ps
`default_nettype none

module core_glue_top
  import core_pkg::*;
(
  input  wire            clk_74a,
  input  wire            rst_n,
  // bridge bus
  input  bridge_word_t   bridge_addr,
  input  wire            bridge_wr,
  input  bridge_word_t   bridge_wr_data,
  output bridge_word_t   bridge_rd_data,
  // read data of the external devices
  input  region_rd_t     region_rd,
  // pads
  input  pad_set_t       cont_keys,
  input  pad_set_t       snac_keys,
  // to the emulator
  output core_settings_t settings,
  output snac_cfg_t      snac_cfg,
  output wire            core_hold,
  output pad_set_t       player_keys
);

  // stored analogizer word, read back over the bridge
  logic [ANALOG_W-1:0] analog_raw;

  ////////////////////
  // write side
  ////////////////////

  bridge_settings_regs i_settings_regs (
    .clk_74a        (clk_74a),
    .rst_n          (rst_n),
    .bridge_addr    (bridge_addr),
    .bridge_wr      (bridge_wr),
    .bridge_wr_data (bridge_wr_data),
    .settings       (settings),
    .snac_cfg       (snac_cfg),
    .analog_raw     (analog_raw),
    .core_hold      (core_hold)
  );

  ////////////////////
  // read side
  ////////////////////

  bridge_read_decode i_read_decode (
    .bridge_addr    (bridge_addr),
    .region_rd      (region_rd),
    .analog_raw     (analog_raw),
    .bridge_rd_data (bridge_rd_data)
  );

  // pad routing follows the analogizer word
  controller_router i_router (
    .clk_74a     (clk_74a),
    .rst_n       (rst_n),
    .snac_cfg    (snac_cfg),
    .cont_keys   (cont_keys),
    .snac_keys   (snac_keys),
    .player_keys (player_keys)
  );

endmodule

`default_nettype wire

// File: verilog/core_pkg.sv
/*
 * core glue package
 * bridge register map, read region codes, analogizer assignment
 * codes and the packed types shared by the bridge-side glue
 */

`default_nettype none

package core_pkg;

  ////////////////////
  // basic types
  ////////////////////

  // one bridge address or data word
  typedef logic [31:0] bridge_word_t;

  // key bitmap of one controller, dpad in [3:0], start in [15]
  typedef logic [15:0] pad_keys_t;

  // players 1 to 4, p1 in the top word
  typedef struct packed {
    pad_keys_t p1;
    pad_keys_t p2;
    pad_keys_t p3;
    pad_keys_t p4;
  } pad_set_t;

  ////////////////////
  // bridge register map
  ////////////////////

  localparam bridge_word_t REG_RESET_HOLD    = 32'h0000_0050;
  localparam bridge_word_t REG_TURBO_TAP     = 32'h0000_0100;
  localparam bridge_word_t REG_BUTTON6       = 32'h0000_0104;
  localparam bridge_word_t REG_B1_TURBO      = 32'h0000_0108;
  localparam bridge_word_t REG_B2_TURBO      = 32'h0000_010C;
  localparam bridge_word_t REG_OVERSCAN      = 32'h0000_0200;
  localparam bridge_word_t REG_EXTRA_SPRITES = 32'h0000_0204;
  localparam bridge_word_t REG_MASTER_BOOST  = 32'h0000_0300;
  localparam bridge_word_t REG_ADPCM_BOOST   = 32'h0000_0304;
  localparam bridge_word_t REG_CD_BOOST      = 32'h0000_0308;
  localparam bridge_word_t REG_ANALOGIZER    = 32'hF700_0000;

  // read region codes, top nibble or top byte of the address
  localparam logic [3:0] SAVE_NIBBLE    = 4'h2;
  localparam logic [3:0] MPU_RAM_NIBBLE = 4'h8;
  localparam logic [7:0] MPU_REG_BYTE   = 8'hF0;
  localparam logic [7:0] CMD_BYTE       = 8'hF8;

  // reset hold, 2^20 cycles needs a 21 bit counter
  localparam int                  HOLD_CNT_W        = 21;
  localparam logic [HOLD_CNT_W-1:0] RESET_HOLD_CYCLES = 21'd1048576;

  // analogizer config word width
  localparam int ANALOG_W = 14;

  ////////////////////
  // enums and structs
  ////////////////////

  typedef enum logic [3:0] {
    ASSIGN_P1       = 4'd0,
    ASSIGN_P2       = 4'd1,
    ASSIGN_P1P2     = 4'd2,
    ASSIGN_SWAP     = 4'd3,
    ASSIGN_ALL      = 4'd4,
    ASSIGN_REVERSED = 4'd5,
    ASSIGN_P3P4     = 4'd6
  } snac_assign_e;

  typedef enum logic [2:0] {
    REGION_NONE,
    REGION_SAVE,
    REGION_ANALOGIZER,
    REGION_MPU_RAM,
    REGION_MPU_REG,
    REGION_CMD
  } bridge_region_e;

  // emulator settings, 12 bits
  typedef struct packed {
    logic       turbo_tap_enable;
    logic       button6_enable;
    logic [1:0] button1_turbo_speed;
    logic [1:0] button2_turbo_speed;
    logic       overscan_enable;
    logic       extra_sprites_enable;
    logic       cd_audio_boost;
    logic       adpcm_audio_boost;
    logic [1:0] master_audio_boost;
  } core_settings_t;

  // same bit layout as the raw 14 bit analogizer word
  typedef struct packed {
    logic [3:0]   video_type;
    snac_assign_e assignment;
    logic         spare;
    logic [4:0]   game_cont_type;
  } snac_cfg_t;

  // read data of the external bridge devices
  typedef struct packed {
    bridge_word_t save_rd;
    bridge_word_t mpu_ram_rd;
    bridge_word_t mpu_reg_rd;
    bridge_word_t cmd_rd;
  } region_rd_t;

endpackage

`default_nettype wire
